//--- Makefile
# Verilator build, run and lint for the interrupt and sleep unit

TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
LINT     := --lint-only --timing -Wall
TOP      := tb_irq_sleep_top
RTL_TOP  := irq_sleep_top
FILELIST := vlog.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A nonzero exit or the fail message in the log fails the target
run: build
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(TOOL) $(LINT) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- irq_arbiter.sv
// Interrupt pending register and fixed-priority arbiter
// Emits a single-cycle acknowledge with the winning ID
`timescale 1ns/1ps
`default_nettype none

module irq_arbiter
  import irq_sleep_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  // External lines and enables
  input  wire irq_vec_t  irq_i,
  input  wire irq_vec_t  mie_i,
  input  wire logic      mstatus_mie_i,
  input  wire priv_lvl_e priv_lvl_i,
  // Pending register view
  output      irq_vec_t  mip_o,
  // Acknowledge towards the core
  output      logic      irq_ack_o,
  output      irq_id_t   irq_id_o,
  // Any pending enabled line, for the sleep controller
  output      logic      irq_wake_o
);

  // ----------------------------------------------------------------------
  // Priority selection
  // ----------------------------------------------------------------------

  // Order: 31 down to 16, then 11, 3, 7
  // Later assignments override earlier ones, so lowest priority goes first
  function automatic irq_id_t pick_winner(irq_vec_t pend);
    irq_id_t id;
    id = '0;
    if (pend[7]) begin
      id = irq_id_t'(7);
    end
    if (pend[3]) begin
      id = irq_id_t'(3);
    end
    if (pend[11]) begin
      id = irq_id_t'(11);
    end
    // Upper platform lines, highest index wins
    for (int i = 16; i < NUM_IRQ; i++) begin
      if (pend[i]) begin
        id = irq_id_t'(i);
      end
    end
    return id;
  endfunction

  irq_vec_t mip_q;
  irq_vec_t pending;
  irq_id_t  win_id;
  logic     glb_en;
  logic     take;
  logic     ack_q;
  irq_id_t  id_q;

  // ----------------------------------------------------------------------
  // Pending register
  // ----------------------------------------------------------------------

  // Reserved lines never reach mip
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_i & VALID_IRQ_MASK;
    end
  end

  assign pending    = mip_q & mie_i;
  assign win_id     = pick_winner(pending);
  assign irq_wake_o = |pending;

  // Machine mode needs mstatus.MIE, user mode is always interruptible
  assign glb_en = ((priv_lvl_i == PRIV_LVL_M) && mstatus_mie_i) ||
                  (priv_lvl_i == PRIV_LVL_U);
  assign take   = irq_wake_o && glb_en;

  // ----------------------------------------------------------------------
  // Acknowledge
  // ----------------------------------------------------------------------

  // Skip the cycle right after an ack so the core sees a pulse
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= take && !ack_q;
    end
  end

  // Latch the winner whenever an interrupt can be taken
  always_ff @(posedge clk_i) begin
    if (take) begin
      id_q <= win_id;
    end
  end

  assign mip_o     = mip_q;
  assign irq_ack_o = ack_q;
  assign irq_id_o  = id_q;

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------

  a_ack_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    irq_ack_o |=> !irq_ack_o
  ) else $error("irq_ack_o held for more than one cycle");

  // Acked ID was implemented and enabled when it was selected
  a_ack_id_legal: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    irq_ack_o |-> |($past(mie_i) & VALID_IRQ_MASK & (irq_vec_t'(1) << irq_id_o))
  ) else $error("acked ID %0d is reserved or disabled", irq_id_o);

endmodule : irq_arbiter

`default_nettype wire

//--- irq_sleep_pkg.sv
// Shared widths, masks, instruction encodings and state types
// for the interrupt and sleep unit
`default_nettype none

package irq_sleep_pkg;

  // ----------------------------------------------------------------------
  // Interrupt lines
  // ----------------------------------------------------------------------

  localparam int unsigned NUM_IRQ = 32;

  // Implemented lines 31..16 plus 11, 7 and 3
  localparam logic [NUM_IRQ-1:0] VALID_IRQ_MASK = 32'hffff_0888;

  // ----------------------------------------------------------------------
  // Sleep instructions and timing
  // ----------------------------------------------------------------------

  localparam logic [31:0] WFI_INSTR = 32'h1050_0073;
  localparam logic [31:0] WFE_INSTR = 32'h8c00_0073;

  // Minimum cycles from the writeback strobe to core sleep
  localparam int unsigned WFI_SLEEP_LATENCY = 2;
  // Width of the latency counter in the sleep controller
  localparam int unsigned SLEEP_LAT_W = $clog2(WFI_SLEEP_LATENCY + 1);

  // Outstanding bus transaction counter width
  localparam int unsigned OUTST_W = 5;

  // ----------------------------------------------------------------------
  // Types
  // ----------------------------------------------------------------------

  typedef logic [NUM_IRQ-1:0] irq_vec_t;
  typedef logic [4:0]         irq_id_t;
  typedef logic [31:0]        instr_word_t;
  typedef logic [OUTST_W-1:0] outst_cnt_t;

  typedef enum logic {
    PRIV_LVL_U = 1'b0,
    PRIV_LVL_M = 1'b1
  } priv_lvl_e;

  // Run -> wait for latency and idle buses -> sleep
  typedef enum logic [1:0] {
    SLP_RUN   = 2'b00,
    SLP_WAIT  = 2'b01,
    SLP_SLEEP = 2'b10
  } sleep_state_e;

endpackage : irq_sleep_pkg

`default_nettype wire

//--- irq_sleep_top.sv
// Interrupt and sleep unit top level
// Arbiter, two bus counters and the sleep controller
`timescale 1ns/1ps
`default_nettype none

module irq_sleep_top
  import irq_sleep_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_ni,
  // Interrupts and CSR state
  input  wire irq_vec_t    irq_i,
  input  wire irq_vec_t    mie_i,
  input  wire logic        mstatus_mie_i,
  input  wire logic        mstatus_tw_i,
  input  wire priv_lvl_e   priv_lvl_i,
  // Writeback stage
  input  wire logic        wb_valid_i,
  input  wire logic        wb_kill_i,
  input  wire instr_word_t wb_instr_i,
  // Debug
  input  wire logic        debug_mode_i,
  input  wire logic        debug_req_i,
  // Instruction bus
  input  wire logic        i_req_i,
  input  wire logic        i_gnt_i,
  input  wire logic        i_rvalid_i,
  // Data bus
  input  wire logic        d_req_i,
  input  wire logic        d_gnt_i,
  input  wire logic        d_rvalid_i,
  // Outputs
  output      irq_vec_t    mip_o,
  output      logic        irq_ack_o,
  output      irq_id_t     irq_id_o,
  output      logic        core_sleep_o
);

  logic irq_wake;

  // ----------------------------------------------------------------------
  // Bus monitor hookup
  // ----------------------------------------------------------------------

  obi_monitor_if i_bus ();
  obi_monitor_if d_bus ();

  assign i_bus.req    = i_req_i;
  assign i_bus.gnt    = i_gnt_i;
  assign i_bus.rvalid = i_rvalid_i;
  assign d_bus.req    = d_req_i;
  assign d_bus.gnt    = d_gnt_i;
  assign d_bus.rvalid = d_rvalid_i;

  obi_outstanding_counter u_i_cnt (.clk_i, .rst_ni, .bus(i_bus));
  obi_outstanding_counter u_d_cnt (.clk_i, .rst_ni, .bus(d_bus));

  // ----------------------------------------------------------------------
  // Interrupts and sleep
  // ----------------------------------------------------------------------

  irq_arbiter u_arb (
    .clk_i, .rst_ni, .irq_i, .mie_i, .mstatus_mie_i, .priv_lvl_i,
    .mip_o, .irq_ack_o, .irq_id_o, .irq_wake_o(irq_wake)
  );

  wfi_sleep_ctrl u_sleep (
    .clk_i, .rst_ni, .wb_valid_i, .wb_kill_i, .wb_instr_i,
    .priv_lvl_i, .mstatus_tw_i, .debug_mode_i, .debug_req_i,
    .irq_wake_i(irq_wake), .i_bus(i_bus), .d_bus(d_bus), .core_sleep_o
  );

endmodule : irq_sleep_top

`default_nettype wire

//--- obi_monitor_if.sv
// OBI bus monitor signals for one bus
// Request side from the top level, idle flag from the counter
`timescale 1ns/1ps
`default_nettype none

interface obi_monitor_if;

  // Address phase handshake
  logic req;
  logic gnt;
  // Response phase
  logic rvalid;
  // No transaction outstanding
  logic idle;

  // Counter side watches the handshake and reports idle
  modport counter (
    input  req,
    input  gnt,
    input  rvalid,
    output idle
  );

  // Sleep logic only needs to know the bus is quiet
  modport observer (
    input idle
  );

endinterface : obi_monitor_if

`default_nettype wire

//--- obi_outstanding_counter.sv
// Outstanding transaction counter for one OBI bus
// Tracks accepted requests still waiting for rvalid and flags idle
`timescale 1ns/1ps
`default_nettype none

module obi_outstanding_counter
  import irq_sleep_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  obi_monitor_if.counter bus
);

  // ----------------------------------------------------------------------
  // Handshake decode
  // ----------------------------------------------------------------------

  // Address phase accepted this cycle
  logic accept;
  // Response delivered this cycle
  logic resp;

  outst_cnt_t cnt_q;

  assign accept = bus.req & bus.gnt;
  assign resp   = bus.rvalid;

  // ----------------------------------------------------------------------
  // Counter
  // ----------------------------------------------------------------------

  // Acceptance and response in the same cycle cancel out
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      unique case ({accept, resp})
        2'b10:   cnt_q <= cnt_q + outst_cnt_t'(1);
        2'b01:   cnt_q <= cnt_q - outst_cnt_t'(1);
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Quiet bus, straight from the count register
  assign bus.idle = (cnt_q == '0);

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------

  // A response needs an earlier accepted request
  a_no_orphan_rvalid: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    bus.rvalid |-> (cnt_q != '0)
  ) else $error("rvalid seen with no outstanding request");

  // Counter must not roll over on a new request
  a_no_wrap: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (accept && !resp) |-> (cnt_q != '1)
  ) else $error("outstanding counter overflow");

endmodule : obi_outstanding_counter

`default_nettype wire

//--- tb_irq_sleep_top.sv
// Testbench for the interrupt and sleep unit
// Random arbitration against a reference model plus directed sleep cases
`timescale 1ns/1ps
`default_nettype none

module tb_irq_sleep_top
  import irq_sleep_pkg::*;
();

  logic        clk_i;
  logic        rst_ni;
  irq_vec_t    irq_i;
  irq_vec_t    mie_i;
  logic        mstatus_mie_i;
  logic        mstatus_tw_i;
  priv_lvl_e   priv_lvl_i;
  logic        wb_valid_i;
  logic        wb_kill_i;
  instr_word_t wb_instr_i;
  logic        debug_mode_i;
  logic        debug_req_i;
  logic        i_req_i;
  logic        i_gnt_i;
  logic        i_rvalid_i;
  logic        d_req_i;
  logic        d_gnt_i;
  logic        d_rvalid_i;
  irq_vec_t    mip_o;
  logic        irq_ack_o;
  irq_id_t     irq_id_o;
  logic        core_sleep_o;

  integer seed;
  int     errors;
  int     checks;
  int     tests;
  int     ack_count;

  irq_sleep_top dut (.*);

  // 100 ns period
  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  // ----------------------------------------------------------------------
  // Reference model and compare tasks
  // ----------------------------------------------------------------------

  // Highest pending line in the order 31..16, 11, 3, 7
  function automatic logic exp_winner(input irq_vec_t pend, output irq_id_t id);
    logic found;
    int   i;
    found = 1'b0;
    id    = '0;
    for (i = NUM_IRQ - 1; i >= 16; i--) begin
      if (!found && pend[i]) begin
        found = 1'b1;
        id    = irq_id_t'(i);
      end
    end
    if (!found && pend[11]) begin
      found = 1'b1;
      id    = irq_id_t'(11);
    end
    if (!found && pend[3]) begin
      found = 1'b1;
      id    = irq_id_t'(3);
    end
    if (!found && pend[7]) begin
      found = 1'b1;
      id    = irq_id_t'(7);
    end
    return found;
  endfunction

  task automatic check_mip(input irq_vec_t got, input irq_vec_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] mip_o got 0x%h expected 0x%h at %0t", got, exp, $time);
    end
  endtask

  task automatic check_irq_id(input irq_id_t got, input irq_id_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] irq_id_o got 0x%h expected 0x%h at %0t", got, exp, $time);
    end
  endtask

  task automatic check_ack(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] irq_ack_o got 0x%h expected 0x%h at %0t", got, exp, $time);
    end
  endtask

  task automatic check_sleep(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] core_sleep_o got 0x%h expected 0x%h at %0t", got, exp, $time);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("%s at %0t", msg, $time);
  endtask

  // Mid-cycle compare, inputs and registers are settled here
  // Model never acks twice in a row
  always @(negedge clk_i) begin : compare_model
    irq_vec_t model_mip;
    logic     model_ack;
    irq_id_t  model_id;
    irq_id_t  win;
    logic     found;
    logic     glb_en;
    if (rst_ni !== 1'b1) begin
      model_mip = '0;
      model_ack = 1'b0;
      model_id  = '0;
    end else begin
      check_mip(mip_o, model_mip);
      check_ack(irq_ack_o, model_ack);
      if (model_ack && irq_ack_o) begin
        check_irq_id(irq_id_o, model_id);
      end
      if (irq_ack_o) begin
        ack_count++;
      end
      // State after the coming rising edge
      found  = exp_winner(model_mip & mie_i, win);
      glb_en = (priv_lvl_i == PRIV_LVL_U) || mstatus_mie_i;
      if (found && glb_en) begin
        model_id = win;
      end
      model_ack = found && glb_en && !model_ack;
      model_mip = irq_i & VALID_IRQ_MASK;
    end
  end

  // ----------------------------------------------------------------------
  // Stimulus helpers
  // ----------------------------------------------------------------------

  // Drive point sits 10 ns after the rising edge
  task automatic step_cycle();
    @(posedge clk_i);
    #10;
  endtask

  task automatic set_idle_inputs();
    irq_i         = '0;
    mie_i         = '0;
    mstatus_mie_i = 1'b1;
    mstatus_tw_i  = 1'b0;
    priv_lvl_i    = PRIV_LVL_M;
    wb_valid_i    = 1'b0;
    wb_kill_i     = 1'b0;
    wb_instr_i    = '0;
    debug_mode_i  = 1'b0;
    debug_req_i   = 1'b0;
  endtask

  // One writeback cycle, returns one edge after the strobe
  task automatic issue_sleep_instr(input instr_word_t instr, input logic kill);
    wb_valid_i = 1'b1;
    wb_instr_i = instr;
    wb_kill_i  = kill;
    step_cycle();
    wb_valid_i = 1'b0;
    wb_instr_i = '0;
    wb_kill_i  = 1'b0;
  endtask

  task automatic expect_awake_for(input int cycles);
    repeat (cycles) begin
      check_sleep(core_sleep_o, 1'b0);
      step_cycle();
    end
  endtask

  task automatic pulse_i_rvalid();
    i_rvalid_i = 1'b1;
    step_cycle();
    i_rvalid_i = 1'b0;
  endtask

  task automatic finish_test(input string name, input int err0);
    tests++;
    if (errors == err0) begin
      $display("test %-14s passed", name);
    end else begin
      $display("test %-14s failed with %0d errors", name, errors - err0);
    end
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------

  initial begin : stimulus
    int err0;
    int acks0;
    int n;
    seed      = 79800;
    errors    = 0;
    checks    = 0;
    tests     = 0;
    ack_count = 0;
    rst_ni    = 1'b0;
    set_idle_inputs();
    i_req_i    = 1'b0;
    i_gnt_i    = 1'b0;
    i_rvalid_i = 1'b0;
    d_req_i    = 1'b0;
    d_gnt_i    = 1'b0;
    d_rvalid_i = 1'b0;
    repeat (3) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;

    // Nothing enabled, so only mip moves
    err0 = errors;
    for (n = 0; n < 40; n++) begin
      irq_i = $random(seed);
      step_cycle();
    end
    finish_test("mip_tracking", err0);

    // Machine mode with global enable, IDs checked by the model
    err0  = errors;
    acks0 = ack_count;
    for (n = 0; n < 200; n++) begin
      irq_i = $random(seed);
      mie_i = $random(seed);
      // Later half leaves only lines 11, 7 and 3 in play
      if (n >= 100) begin
        irq_i[31:16] = '0;
        mie_i        = mie_i | 32'h0000_0888;
      end
      step_cycle();
    end
    if (ack_count == acks0) begin
      report_error("No acknowledge seen during random arbitration");
    end
    finish_test("arbitration", err0);

    err0          = errors;
    mstatus_mie_i = 1'b0;
    irq_i         = VALID_IRQ_MASK;
    mie_i         = '1;
    repeat (2) step_cycle();
    acks0 = ack_count;
    repeat (20) step_cycle();
    if (ack_count != acks0) begin
      report_error("Acknowledge seen in machine mode with global enable low");
    end
    // User mode ignores mstatus.MIE
    priv_lvl_i = PRIV_LVL_U;
    n = 0;
    while (ack_count == acks0 && n < 10) begin
      step_cycle();
      n++;
    end
    if (ack_count == acks0) begin
      report_error("Timeout waiting for an acknowledge in user mode");
    end
    finish_test("global_gating", err0);

    // Line 16 pending but disabled, kept for the wake case
    err0 = errors;
    set_idle_inputs();
    irq_i = 32'h0001_0000;
    repeat (2) step_cycle();
    check_sleep(core_sleep_o, 1'b0);
    issue_sleep_instr(WFI_INSTR, 1'b0);
    for (n = 1; n < WFI_SLEEP_LATENCY; n++) begin
      check_sleep(core_sleep_o, 1'b0);
      step_cycle();
    end
    check_sleep(core_sleep_o, 1'b1);
    finish_test("sleep_entry", err0);

    // Enable the pending line, then a debug request
    err0  = errors;
    mie_i = 32'h0001_0000;
    step_cycle();
    check_sleep(core_sleep_o, 1'b0);
    mie_i = '0;
    irq_i = '0;
    repeat (2) step_cycle();
    issue_sleep_instr(WFE_INSTR, 1'b0);
    repeat (WFI_SLEEP_LATENCY - 1) step_cycle();
    check_sleep(core_sleep_o, 1'b1);
    debug_req_i = 1'b1;
    step_cycle();
    check_sleep(core_sleep_o, 1'b0);
    debug_req_i = 1'b0;
    finish_test("wake", err0);

    // TW trap in user mode, then a killed writeback
    err0         = errors;
    priv_lvl_i   = PRIV_LVL_U;
    mstatus_tw_i = 1'b1;
    issue_sleep_instr(WFI_INSTR, 1'b0);
    expect_awake_for(5);
    priv_lvl_i   = PRIV_LVL_M;
    mstatus_tw_i = 1'b0;
    issue_sleep_instr(WFI_INSTR, 1'b1);
    expect_awake_for(5);
    finish_test("sleep_blocked", err0);

    // Two accepted fetches hold off sleep until both responses
    err0    = errors;
    i_req_i = 1'b1;
    i_gnt_i = 1'b1;
    repeat (2) step_cycle();
    i_req_i = 1'b0;
    i_gnt_i = 1'b0;
    issue_sleep_instr(WFI_INSTR, 1'b0);
    expect_awake_for(4);
    pulse_i_rvalid();
    expect_awake_for(3);
    pulse_i_rvalid();
    check_sleep(core_sleep_o, 1'b0);
    n = 0;
    while (!core_sleep_o && n < 10) begin
      step_cycle();
      n++;
    end
    if (!core_sleep_o) begin
      report_error("Timeout waiting for sleep after the bus drained");
    end
    debug_req_i = 1'b1;
    step_cycle();
    debug_req_i = 1'b0;
    finish_test("bus_blocking", err0);

    step_cycle();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : tb_irq_sleep_top

`default_nettype wire

//--- vlog.f
irq_sleep_pkg.sv
obi_monitor_if.sv
obi_outstanding_counter.sv
irq_arbiter.sv
wfi_sleep_ctrl.sv
irq_sleep_top.sv
tb_irq_sleep_top.sv

//--- wfi_sleep_ctrl.sv
// WFI/WFE sleep controller
// Decodes sleep instructions at writeback and gates core sleep on bus idle
`timescale 1ns/1ps
`default_nettype none

module wfi_sleep_ctrl
  import irq_sleep_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_ni,
  // Writeback stage
  input  wire logic        wb_valid_i,
  input  wire logic        wb_kill_i,
  input  wire instr_word_t wb_instr_i,
  // Privilege and CSR state
  input  wire priv_lvl_e   priv_lvl_i,
  input  wire logic        mstatus_tw_i,
  // Debug
  input  wire logic        debug_mode_i,
  input  wire logic        debug_req_i,
  // Wake from the arbiter
  input  wire logic        irq_wake_i,
  // Bus idle flags
  obi_monitor_if.observer  i_bus,
  obi_monitor_if.observer  d_bus,
  output      logic        core_sleep_o
);

  sleep_state_e state_q;
  sleep_state_e state_d;

  // Cycles elapsed since the strobe
  logic [SLEEP_LAT_W-1:0] lat_cnt_q;
  logic [SLEEP_LAT_W-1:0] lat_cnt_d;

  logic is_sleep_instr;
  logic tw_trap;
  logic wfi_strobe;
  logic wake;
  logic bus_idle;
  logic lat_done;

  // ----------------------------------------------------------------------
  // Writeback decode
  // ----------------------------------------------------------------------

  assign is_sleep_instr = (wb_instr_i == WFI_INSTR) || (wb_instr_i == WFE_INSTR);

  // U-mode WFI with TW set traps instead of sleeping
  assign tw_trap = (priv_lvl_i == PRIV_LVL_U) && mstatus_tw_i;

  assign wfi_strobe = wb_valid_i && is_sleep_instr && !wb_kill_i &&
                      !debug_mode_i && !tw_trap;

  assign wake     = irq_wake_i || debug_req_i;
  assign bus_idle = i_bus.idle && d_bus.idle;
  assign lat_done = (lat_cnt_q >= SLEEP_LAT_W'(WFI_SLEEP_LATENCY - 1));

  // ----------------------------------------------------------------------
  // Sleep FSM
  // ----------------------------------------------------------------------

  always_comb begin
    state_d   = state_q;
    lat_cnt_d = lat_cnt_q;
    // Wake overrides everything, even a fresh strobe
    if (wake) begin
      state_d   = SLP_RUN;
      lat_cnt_d = '0;
    end else begin
      unique case (state_q)
        SLP_RUN: begin
          if (wfi_strobe) begin
            state_d   = SLP_WAIT;
            // Strobe edge counts as the first cycle
            lat_cnt_d = SLEEP_LAT_W'(1);
          end
        end
        SLP_WAIT: begin
          if (lat_done && bus_idle) begin
            state_d = SLP_SLEEP;
          end else if (!lat_done) begin
            lat_cnt_d = lat_cnt_q + SLEEP_LAT_W'(1);
          end
        end
        // Held until a wake source shows up
        SLP_SLEEP: state_d = SLP_SLEEP;
        default:   state_d = SLP_RUN;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= SLP_RUN;
      lat_cnt_q <= '0;
    end else begin
      state_q   <= state_d;
      lat_cnt_q <= lat_cnt_d;
    end
  end

  assign core_sleep_o = (state_q == SLP_SLEEP);

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------

  // Sleep is only entered from the wait state with both buses quiet
  a_sleep_via_wait: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(core_sleep_o) |-> ($past(state_q) == SLP_WAIT) && $past(bus_idle)
  ) else $error("core_sleep_o rose without passing through wait");

  a_wake_drops_sleep: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (core_sleep_o && wake) |=> !core_sleep_o
  ) else $error("core_sleep_o stayed high after wake");

endmodule : wfi_sleep_ctrl

`default_nettype wire
